// File: build.f
+incdir+hw
hw/axi_pkg.sv
hw/lsu_pkg.sv
hw/axil_if.sv
hw/lsu.sv
hw/axil_sram.sv
hw/lsu_top.sv
dv/tb_lsu_top.sv

// File: run.sh
#!/usr/bin/env bash
# Compiles the load/store subsystem with its testbench under Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_lsu_top -f build.f -o sim_lsu

./obj_dir/sim_lsu | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure, see sim.log."
	exit 1
fi
if ! grep -q "Test passed" sim.log; then
	echo "Simulation ended without a result line, see sim.log."
	exit 1
fi
echo "Simulation finished cleanly."

// File: dv/tb_lsu_top.sv
// Self-checking testbench for lsu_top, compiled from build.f and run by run.sh.
`timescale 1ns/1ps
`include "lsu_config.svh"

module tb_lsu_top
	import lsu_pkg::*;
();

	localparam int MEM_BYTES = `LSU_MEM_WORDS * 8;
	localparam logic [`LSU_XLEN-1:0] MEM_END = `LSU_XLEN'(MEM_BYTES);
	localparam int WAIT_LIMIT = 200;  // Cycles allowed for any single wait.
	localparam int RT_ROUNDS = 40;
	localparam lsu_op_e STORE_OPS [4] = '{OP_SB, OP_SH, OP_SW, OP_SD};
	localparam lsu_op_e LOAD_OPS [7] = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};

	typedef struct packed {
		lsu_tag_t             rd;
		logic [`LSU_XLEN-1:0] data;
		logic                 err;
	} wb_exp_t;

	logic CLK;
	logic rst_n;
	logic issue_valid;
	logic issue_ready;
	lsu_op_e issue_op;
	lsu_tag_t issue_rd;
	logic [`LSU_XLEN-1:0] issue_addr;
	logic [`LSU_XLEN-1:0] issue_data;
	logic wb_valid;
	lsu_tag_t wb_rd;
	logic [`LSU_XLEN-1:0] wb_data;
	logic wb_err;
	logic flush;

	wb_exp_t expect_q [$];  // Results of accepted instructions, oldest first.
	wb_exp_t exp_cur;
	logic exp_ok;
	logic [7:0] model [MEM_BYTES];  // Byte image of the SRAM.
	logic [31:0] rng_state;
	int wb_errors;
	int step_errors;
	int timeouts;

	lsu_top dut0 (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue_op    (issue_op),
		.issue_rd    (issue_rd),
		.issue_addr  (issue_addr),
		.issue_data  (issue_data),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.wb_err      (wb_err),
		.flush       (flush)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// ##########################################################################
	// Writeback checking
	// ##########################################################################

	// The front entry is taken while wb_valid is stable, then checked on the next edge.
	always @(negedge CLK) begin
		if (wb_valid) begin
			exp_ok = (expect_q.size() > 0);
			if (exp_ok) exp_cur = expect_q.pop_front();
		end
	end

	a_wb_expected: assert property (@(posedge CLK) disable iff (!rst_n) wb_valid |-> exp_ok)
		else begin
			wb_errors++;
			$display("Writeback at %0t with no instruction pending", $time);
		end

	a_wb_rd: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_valid && exp_ok |-> wb_rd == exp_cur.rd)
		else begin
			wb_errors++;
			$display("[ERROR] %0t wb_rd: expected %h, got %h", $time, exp_cur.rd,
				$sampled(wb_rd));
		end

	a_wb_data: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_valid && exp_ok |-> wb_data == exp_cur.data)
		else begin
			wb_errors++;
			$display("[ERROR] %0t wb_data: expected %h, got %h", $time, exp_cur.data,
				$sampled(wb_data));
		end

	a_wb_err: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_valid && exp_ok |-> wb_err == exp_cur.err)
		else begin
			wb_errors++;
			$display("[ERROR] %0t wb_err: expected %b, got %b", $time, exp_cur.err,
				$sampled(wb_err));
		end

	// ##########################################################################
	// Helpers
	// ##########################################################################

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic logic [`LSU_XLEN-1:0] rand64();
		logic [31:0] hi;
		hi = xorshift32();
		return {hi, xorshift32()};
	endfunction

	function automatic int op_bytes(lsu_op_e op);
		case (op)
			OP_LB, OP_LBU, OP_SB: return 1;
			OP_LH, OP_LHU, OP_SH: return 2;
			OP_LW, OP_LWU, OP_SW: return 4;
			OP_LD, OP_SD: return 8;
			default: return 0;
		endcase
	endfunction

	// Random SRAM address aligned to an access of n bytes.
	function automatic logic [`LSU_XLEN-1:0] random_addr(int n);
		int word;
		int lane;
		word = int'(xorshift32() >> 1) % `LSU_MEM_WORDS;
		lane = int'(xorshift32() >> 29) & ~(n - 1);
		return `LSU_MEM_BASE + `LSU_XLEN'(word * 8 + lane);
	endfunction

	// Bytes from the model, sign or zero extended by the load opcode.
	function automatic logic [`LSU_XLEN-1:0] load_value(lsu_op_e op, int idx);
		int n;
		logic fill;
		logic [`LSU_XLEN-1:0] v;
		n = op_bytes(op);
		v = '0;
		for (int i = 0; i < n; i++) v[i*8 +: 8] = model[idx + i];
		fill = (op inside {OP_LB, OP_LH, OP_LW}) && v[n*8-1];
		for (int i = n * 8; i < `LSU_XLEN; i++) v[i] = fill;
		return v;
	endfunction

	task automatic end_run();
		$display("Errors: %0d writeback, %0d step, %0d timeouts", wb_errors, step_errors,
			timeouts);
		if (wb_errors == 0 && step_errors == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout at %0t: %s", $time, what);
		end_run();
	endtask

	// Drives one instruction from a falling edge and records what it must write back.
	task automatic issue_instr(input lsu_op_e op, input logic [`LSU_XLEN-1:0] addr,
			input logic [`LSU_XLEN-1:0] data, input logic expect_wb);
		int waited;
		int n;
		int idx;
		logic [`LSU_XLEN-1:0] off;
		logic in_range;
		logic is_ld;
		logic is_st;
		wb_exp_t e;
		e.rd = lsu_tag_t'(xorshift32());
		issue_valid = 1'b1;
		issue_op = op;
		issue_rd = e.rd;
		issue_addr = addr;
		issue_data = data;
		waited = 0;
		while (!issue_ready && waited < WAIT_LIMIT) begin
			@(negedge CLK);
			waited++;
		end
		if (!issue_ready) report_timeout("issue_ready stayed low for the next instruction");
		// Accepted on the coming rising edge.
		n = op_bytes(op);
		off = addr - `LSU_MEM_BASE;
		idx = int'(off[15:0]);
		in_range = (off < MEM_END);
		is_ld = (op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU});
		is_st = (op inside {OP_SB, OP_SH, OP_SW, OP_SD});
		e.err = (is_ld || is_st) && !in_range;
		e.data = (is_ld && in_range) ? load_value(op, idx) : '0;
		if (is_st && in_range) begin
			for (int i = 0; i < n; i++) model[idx + i] = data[i*8 +: 8];
		end
		if (expect_wb) expect_q.push_back(e);
		@(negedge CLK);
		issue_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (expect_q.size() > 0 && waited < WAIT_LIMIT) begin
			@(negedge CLK);
			waited++;
		end
		if (expect_q.size() > 0) report_timeout("expected writebacks never arrived");
		@(negedge CLK);  // The last writeback is checked on the rising edge in between.
	endtask

	// ##########################################################################
	// Stimulus
	// ##########################################################################

	initial begin
		logic [`LSU_XLEN-1:0] addr;
		int waited;
		rng_state = 32'heee1_64d5;
		wb_errors = 0;
		step_errors = 0;
		timeouts = 0;
		exp_ok = 1'b0;
		issue_valid = 1'b0;
		issue_op = OP_LD;
		issue_rd = '0;
		issue_addr = '0;
		issue_data = '0;
		flush = 1'b0;
		for (int i = 0; i < MEM_BYTES; i++) model[i] = 8'h00;

		rst_n = 1'b1;
		#1 rst_n = 1'b0;  // A real falling edge starts the asynchronous reset.
		repeat (4) begin
			@(negedge CLK);
			assert (!wb_valid) else begin
				step_errors++;
				$display("[ERROR] %0t wb_valid: expected 0, got %b", $time, wb_valid);
			end
		end
		rst_n = 1'b1;
		@(negedge CLK);
		assert (!wb_valid) else begin
			step_errors++;
			$display("[ERROR] %0t wb_valid: expected 0, got %b", $time, wb_valid);
		end
		waited = 0;
		while (!issue_ready && waited < WAIT_LIMIT) begin
			@(negedge CLK);
			waited++;
		end
		if (!issue_ready) report_timeout("issue_ready never rose after reset");

		// Every word gets a pattern from its full address, so later loads read defined data.
		for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
			addr = `LSU_MEM_BASE + `LSU_XLEN'(w * 8);
			issue_instr(OP_SD, addr, (addr * 64'h9e37_79b9_7f4a_7c15) ^ ~addr, 1'b1);
		end
		wait_drain();

		for (int r = 0; r < RT_ROUNDS; r++) begin
			addr = random_addr(op_bytes(STORE_OPS[r % 4]));
			issue_instr(STORE_OPS[r % 4], addr, rand64(), 1'b1);
			for (int k = 0; k < 7; k++) begin
				issue_instr(LOAD_OPS[k], addr & ~`LSU_XLEN'(op_bytes(LOAD_OPS[k]) - 1), '0, 1'b1);
			end
		end
		wait_drain();

		repeat (8) begin
			addr = random_addr(8);
			issue_instr(OP_SD, addr, rand64(), 1'b1);
			issue_instr(OP_SB, addr + `LSU_XLEN'(xorshift32() >> 29), rand64(), 1'b1);
			issue_instr(OP_LD, addr, '0, 1'b1);
		end
		wait_drain();

		// Fences answer in the cycle right after acceptance.
		issue_instr(OP_FENCE, '0, '0, 1'b1);
		assert (wb_valid) else begin
			step_errors++;
			$display("[ERROR] %0t wb_valid: expected 1, got %b", $time, wb_valid);
		end
		issue_instr(OP_FENCE_I, '0, '0, 1'b1);
		assert (wb_valid) else begin
			step_errors++;
			$display("[ERROR] %0t wb_valid: expected 1, got %b", $time, wb_valid);
		end
		issue_instr(OP_LD, random_addr(8), '0, 1'b1);
		wait_drain();

		// The flushed load completes on the bus but must not write back.
		addr = random_addr(8);
		issue_instr(OP_LD, addr, '0, 1'b0);
		flush = 1'b1;
		@(negedge CLK);
		flush = 1'b0;
		issue_instr(OP_LW, addr, '0, 1'b1);
		wait_drain();

		addr = random_addr(8);
		issue_instr(OP_SD, MEM_END + addr, rand64(), 1'b1);
		issue_instr(OP_LD, MEM_END + addr, '0, 1'b1);
		issue_instr(OP_LW, (MEM_END << 1) + addr, '0, 1'b1);
		issue_instr(OP_LD, addr, '0, 1'b1);  // Same index inside the SRAM, unchanged.
		wait_drain();

		end_run();
	end

endmodule

// File: hw/lsu_top.sv
// Top level of the load/store subsystem with plain ports, the DUT of the testbench.
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_top
	import lsu_pkg::*;
(
	input  logic                 CLK,
	input  logic                 rst_n,

	// Issue port.
	input  logic                 issue_valid,
	output logic                 issue_ready,
	input  lsu_op_e              issue_op,
	input  lsu_tag_t             issue_rd,
	input  logic [`LSU_XLEN-1:0] issue_addr,
	input  logic [`LSU_XLEN-1:0] issue_data,

	// Writeback port, no back-pressure.
	output logic                 wb_valid,
	output lsu_tag_t             wb_rd,
	output logic [`LSU_XLEN-1:0] wb_data,
	output logic                 wb_err,

	input  logic                 flush
);

	lsu_issue_t issue;

	assign issue = '{op: issue_op, tag: issue_rd, addr: issue_addr, data: issue_data};

	axil_if bus0 ();

	lsu lsu0 (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue       (issue),
		.flush       (flush),
		.bus         (bus0.master),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.wb_err      (wb_err)
	);

	axil_sram sram0 (
		.CLK   (CLK),
		.rst_n (rst_n),
		.bus   (bus0.slave)
	);

endmodule

// File: hw/axil_sram.sv
// AXI4-Lite SRAM slave with byte strobes and range check, placed behind the unit by lsu_top.
`timescale 1ns/1ps
`include "lsu_config.svh"

module axil_sram
	import axi_pkg::*;
(
	input logic   CLK,
	input logic   rst_n,
	axil_if.slave bus
);

	localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
	localparam logic [`LSU_XLEN-1:0] MEM_BYTES = `LSU_XLEN'(`LSU_MEM_WORDS * 8);

	axil_sram_state_e state;
	logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

	logic aw_got;  // AW taken, still waiting for W.
	logic w_got;  // W taken, still waiting for AW.
	logic [`LSU_XLEN-1:0] awaddr_q;
	logic [`LSU_XLEN-1:0] wdata_q;
	logic [`LSU_XLEN/8-1:0] wstrb_q;
	logic [`LSU_XLEN-1:0] rdata_q;
	axi_resp_e bresp_q;
	axi_resp_e rresp_q;

	logic aw_xfer;
	logic w_xfer;
	logic ar_xfer;
	logic wr_fire;
	logic [`LSU_XLEN-1:0] wr_off;
	logic [`LSU_XLEN-1:0] wr_data;
	logic [`LSU_XLEN/8-1:0] wr_strb;
	logic [`LSU_XLEN-1:0] rd_off;
	logic wr_ok;
	logic rd_ok;

	// Write wins over a read that shows up in the same cycle.
	assign bus.awready = (state == SR_IDLE) & ~aw_got;
	assign bus.wready = (state == SR_IDLE) & ~w_got;
	assign bus.arready = (state == SR_IDLE) & ~aw_got & ~w_got & ~bus.awvalid & ~bus.wvalid;
	assign bus.bvalid = (state == SR_BRESP);
	assign bus.bresp = bresp_q;
	assign bus.rvalid = (state == SR_RRESP);
	assign bus.rresp = rresp_q;
	assign bus.rdata = rdata_q;

	assign aw_xfer = bus.awvalid & bus.awready;
	assign w_xfer = bus.wvalid & bus.wready;
	assign ar_xfer = bus.arvalid & bus.arready;
	assign wr_fire = (aw_got | aw_xfer) & (w_got | w_xfer);

	// Take each half of the write from the bus if it arrives now, else from its latch.
	assign wr_off = (aw_got ? awaddr_q : bus.awaddr) - `LSU_MEM_BASE;
	assign wr_data = w_got ? wdata_q : bus.wdata;
	assign wr_strb = w_got ? wstrb_q : bus.wstrb;
	assign rd_off = bus.araddr - `LSU_MEM_BASE;

	// Below the base the offset wraps to a large value, so one compare covers both ends.
	assign wr_ok = (wr_off < MEM_BYTES);
	assign rd_ok = (rd_off < MEM_BYTES);

	always_ff @(posedge CLK) begin
		if (aw_xfer) awaddr_q <= bus.awaddr;
		if (w_xfer) begin
			wdata_q <= bus.wdata;
			wstrb_q <= bus.wstrb;
		end
		if (wr_fire) begin
			bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
			for (int i = 0; i < `LSU_XLEN/8; i++) begin
				if (wr_ok && wr_strb[i]) mem[wr_off[3 +: IDX_W]][i*8 +: 8] <= wr_data[i*8 +: 8];
			end
		end
		if (ar_xfer) begin
			rdata_q <= rd_ok ? mem[rd_off[3 +: IDX_W]] : '0;
			rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= SR_IDLE;
			aw_got <= 1'b0;
			w_got <= 1'b0;
		end else begin
			case (state)
				SR_IDLE: begin
					if (wr_fire) begin
						aw_got <= 1'b0;
						w_got <= 1'b0;
						state <= SR_BRESP;
					end else begin
						if (aw_xfer) aw_got <= 1'b1;
						if (w_xfer) w_got <= 1'b1;
						if (ar_xfer) state <= SR_RRESP;
					end
				end
				SR_BRESP: if (bus.bready) state <= SR_IDLE;
				SR_RRESP: if (bus.rready) state <= SR_IDLE;
				default: state <= SR_IDLE;
			endcase
		end
	end

	a_b_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		bus.bvalid && !bus.bready |=> bus.bvalid && $stable(bus.bresp))
		else $error("axil_sram: B response dropped before bready");

	a_r_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata))
		else $error("axil_sram: R response dropped before rready");

endmodule

// File: hw/lsu.sv
// RV64 load/store unit, the AXI4-Lite master that lsu_top places in front of the SRAM.
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu
	import lsu_pkg::*;
	import axi_pkg::*;
(
	input  logic                 CLK,
	input  logic                 rst_n,

	input  logic                 issue_valid,
	output logic                 issue_ready,
	input  lsu_issue_t           issue,
	input  logic                 flush,

	axil_if.master               bus,

	output logic                 wb_valid,
	output lsu_tag_t             wb_rd,
	output logic [`LSU_XLEN-1:0] wb_data,
	output logic                 wb_err
);

	lsu_state_e state;
	logic ready_en;  // Keeps issue_ready low in the first cycle out of reset.
	logic aw_done;
	logic w_done;
	logic bready_q;
	logic rready_q;
	logic drop_q;  // Set by a flush while the bus transaction is in flight.

	logic is_load;
	logic is_store;
	logic is_fence;
	logic acc_unsigned;
	logic [1:0] acc_size;  // Log2 of the access width in bytes.
	logic [2:0] align_mask;
	logic [`LSU_XLEN/8-1:0] strb_base;
	logic misaligned;
	logic accept;

	logic [`LSU_XLEN-1:0] addr_q;
	logic [`LSU_XLEN-1:0] wdata_q;
	logic [`LSU_XLEN/8-1:0] wstrb_q;
	logic [1:0] ld_size_q;
	logic ld_unsigned_q;

	logic aw_xfer;
	logic w_xfer;
	logic b_xfer;
	logic ar_xfer;
	logic r_xfer;
	logic kill;
	logic [`LSU_XLEN-1:0] rd_shift;
	logic [`LSU_XLEN-1:0] ld_ext;

	// ##########################################################################
	// Decode of the issued instruction
	// ##########################################################################

	always_comb begin
		is_load = 1'b0;
		is_store = 1'b0;
		is_fence = 1'b0;
		acc_unsigned = 1'b0;
		acc_size = 2'd3;
		case (issue.op)
			OP_LB, OP_LBU: begin
				is_load = 1'b1;
				acc_size = 2'd0;
				acc_unsigned = (issue.op == OP_LBU);
			end
			OP_LH, OP_LHU: begin
				is_load = 1'b1;
				acc_size = 2'd1;
				acc_unsigned = (issue.op == OP_LHU);
			end
			OP_LW, OP_LWU: begin
				is_load = 1'b1;
				acc_size = 2'd2;
				acc_unsigned = (issue.op == OP_LWU);
			end
			OP_LD: is_load = 1'b1;
			OP_SB: begin
				is_store = 1'b1;
				acc_size = 2'd0;
			end
			OP_SH: begin
				is_store = 1'b1;
				acc_size = 2'd1;
			end
			OP_SW: begin
				is_store = 1'b1;
				acc_size = 2'd2;
			end
			OP_SD: is_store = 1'b1;
			default: is_fence = 1'b1;  // FENCE and FENCE.I need no bus access.
		endcase
	end

	// The access width sets both the alignment check and the unshifted strobe.
	always_comb begin
		case (acc_size)
			2'd0: begin
				align_mask = 3'b000;
				strb_base = 8'h01;
			end
			2'd1: begin
				align_mask = 3'b001;
				strb_base = 8'h03;
			end
			2'd2: begin
				align_mask = 3'b011;
				strb_base = 8'h0f;
			end
			default: begin
				align_mask = 3'b111;
				strb_base = 8'hff;
			end
		endcase
	end

	assign misaligned = (is_load | is_store) & (|(issue.addr[2:0] & align_mask));
	assign issue_ready = ready_en & (state == ST_IDLE);
	assign accept = issue_valid & issue_ready & ~flush;  // A same-cycle flush drops the issue.

	// ##########################################################################
	// AXI master channels
	// ##########################################################################

	assign bus.awaddr = addr_q;
	assign bus.awprot = AXI_PROT_DATA;
	assign bus.awvalid = (state == ST_WRITE) & ~aw_done;
	assign bus.wdata = wdata_q;
	assign bus.wstrb = wstrb_q;
	assign bus.wvalid = (state == ST_WRITE) & ~w_done;
	assign bus.bready = bready_q;
	assign bus.araddr = addr_q;
	assign bus.arprot = AXI_PROT_PRIV;
	assign bus.arvalid = (state == ST_READ);
	assign bus.rready = rready_q;

	assign aw_xfer = bus.awvalid & bus.awready;
	assign w_xfer = bus.wvalid & bus.wready;
	assign b_xfer = bus.bvalid & bus.bready;
	assign ar_xfer = bus.arvalid & bus.arready;
	assign r_xfer = bus.rvalid & bus.rready;
	assign kill = drop_q | flush;

	// Move the addressed lane down to bit 0, then extend by the load width.
	assign rd_shift = bus.rdata >> {addr_q[2:0], 3'b000};

	always_comb begin
		case (ld_size_q)
			2'd0: ld_ext = ld_unsigned_q ? {{(`LSU_XLEN-8){1'b0}}, rd_shift[7:0]} :
					{{(`LSU_XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
			2'd1: ld_ext = ld_unsigned_q ? {{(`LSU_XLEN-16){1'b0}}, rd_shift[15:0]} :
					{{(`LSU_XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
			2'd2: ld_ext = ld_unsigned_q ? {{(`LSU_XLEN-32){1'b0}}, rd_shift[31:0]} :
					{{(`LSU_XLEN-32){rd_shift[31]}}, rd_shift[31:0]};
			default: ld_ext = rd_shift;
		endcase
	end

	// Accepted instruction and the writeback payload.
	always_ff @(posedge CLK) begin
		if (accept) begin
			addr_q <= issue.addr;
			wdata_q <= issue.data << {issue.addr[2:0], 3'b000};
			wstrb_q <= strb_base << issue.addr[2:0];
			ld_size_q <= acc_size;
			ld_unsigned_q <= acc_unsigned;
			wb_rd <= issue.tag;
			wb_data <= '0;  // Stores and fences write back zero.
			wb_err <= 1'b0;
		end
		if (b_xfer) wb_err <= (bus.bresp != RESP_OKAY);
		if (r_xfer) begin
			wb_err <= (bus.rresp != RESP_OKAY);
			wb_data <= (bus.rresp == RESP_OKAY) ? ld_ext : '0;
		end
	end

	// ##########################################################################
	// Sequencing
	// ##########################################################################

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			ready_en <= 1'b0;
			aw_done <= 1'b0;
			w_done <= 1'b0;
			bready_q <= 1'b0;
			rready_q <= 1'b0;
			drop_q <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			ready_en <= 1'b1;
			wb_valid <= 1'b0;  // Single-cycle pulse.
			if (flush) drop_q <= 1'b1;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						drop_q <= 1'b0;
						aw_done <= 1'b0;
						w_done <= 1'b0;
						if (is_store) state <= ST_WRITE;
						else if (is_load) state <= ST_READ;
						else if (is_fence) begin
							state <= ST_WB;
							wb_valid <= 1'b1;
						end
					end
				end
				ST_WRITE: begin
					// AW and W may be taken on different edges.
					if (aw_xfer) aw_done <= 1'b1;
					if (w_xfer) w_done <= 1'b1;
					if ((aw_done | aw_xfer) && (w_done | w_xfer)) state <= ST_WAIT_B;
				end
				ST_READ: if (ar_xfer) state <= ST_WAIT_R;
				ST_WAIT_B: begin
					if (b_xfer) begin
						bready_q <= 1'b0;
						wb_valid <= ~kill;
						state <= kill ? ST_IDLE : ST_WB;
					end else if (bus.bvalid) bready_q <= 1'b1;
				end
				ST_WAIT_R: begin
					if (r_xfer) begin
						rready_q <= 1'b0;
						wb_valid <= ~kill;
						state <= kill ? ST_IDLE : ST_WB;
					end else if (bus.rvalid) rready_q <= 1'b1;
				end
				default: state <= ST_IDLE;  // ST_WB lasts one cycle.
			endcase
		end
	end

	a_aligned: assert property (@(posedge CLK) disable iff (!rst_n) accept |-> !misaligned)
		else $error("lsu: misaligned access accepted");

	a_aw_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		bus.awvalid && !bus.awready |=> bus.awvalid && $stable(bus.awaddr))
		else $error("lsu: AW dropped before awready");

	a_wb_pulse: assert property (@(posedge CLK) disable iff (!rst_n) wb_valid |=> !wb_valid)
		else $error("lsu: wb_valid high on two consecutive cycles");

endmodule

// File: hw/axil_if.sv
// AXI4-Lite bus bundle joining the load/store unit to the SRAM through master and slave modports.
`timescale 1ns/1ps
`include "lsu_config.svh"

interface axil_if
	import axi_pkg::*;
();

	// Write address channel.
	logic [`LSU_XLEN-1:0]   awaddr;
	logic [2:0]             awprot;
	logic                   awvalid;
	logic                   awready;

	// Write data channel.
	logic [`LSU_XLEN-1:0]   wdata;
	logic [`LSU_XLEN/8-1:0] wstrb;  // One bit per byte lane.
	logic                   wvalid;
	logic                   wready;

	// Write response channel.
	axi_resp_e              bresp;
	logic                   bvalid;
	logic                   bready;

	// Read address and read data channels.
	logic [`LSU_XLEN-1:0]   araddr;
	logic [2:0]             arprot;
	logic                   arvalid;
	logic                   arready;
	logic [`LSU_XLEN-1:0]   rdata;
	axi_resp_e              rresp;
	logic                   rvalid;
	logic                   rready;

	modport master (
		output awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
		output araddr, arprot, arvalid, rready,
		input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

	modport slave (
		input  awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
		input  araddr, arprot, arvalid, rready,
		output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

endinterface

// File: hw/lsu_pkg.sv
// Instruction-side types of the load/store unit, imported by the unit and by its top level.
`include "lsu_config.svh"

package lsu_pkg;

	// A destination tag is the register index widened by the rename bits.
	localparam int LSU_TAG_W = 5 + `LSU_RB;

	typedef logic [LSU_TAG_W-1:0] lsu_tag_t;

	// Memory opcodes as they leave the decoder.
	typedef enum logic [3:0] {
		OP_LB      = 4'd0,
		OP_LH      = 4'd1,
		OP_LW      = 4'd2,
		OP_LD      = 4'd3,
		OP_LBU     = 4'd4,
		OP_LHU     = 4'd5,
		OP_LWU     = 4'd6,
		OP_SB      = 4'd7,
		OP_SH      = 4'd8,
		OP_SW      = 4'd9,
		OP_SD      = 4'd10,
		OP_FENCE   = 4'd11,
		OP_FENCE_I = 4'd12
	} lsu_op_e;

	typedef struct packed {
		lsu_op_e              op;
		lsu_tag_t             tag;
		logic [`LSU_XLEN-1:0] addr;  // Effective byte address.
		logic [`LSU_XLEN-1:0] data;  // Store data, right aligned. Ignored by loads.
	} lsu_issue_t;

	// Unit sequencing, one transaction at a time.
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ,
		ST_WAIT_B,
		ST_WAIT_R,
		ST_WB
	} lsu_state_e;

endpackage

// File: hw/axi_pkg.sv
// Bus-side types for the AXI4-Lite master and slave, imported by the interface, unit and SRAM.

package axi_pkg;

	// ##########################################################################
	// Responses and protection
	// ##########################################################################

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

	// Unprivileged secure data access, used for every write.
	localparam logic [2:0] AXI_PROT_DATA = 3'b000;
	// Privileged secure data access, used for every read.
	localparam logic [2:0] AXI_PROT_PRIV = 3'b001;

	// ##########################################################################
	// SRAM slave
	// ##########################################################################

	typedef enum logic [1:0] {
		SR_IDLE,
		SR_BRESP,  // Write done, holding the B response.
		SR_RRESP   // Read done, holding the R response.
	} axil_sram_state_e;

endpackage

// File: hw/lsu_config.svh
// Build parameters of the load/store subsystem, included by every RTL file and the testbench.
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ##########################################################################
// Datapath
// ##########################################################################

// Register, address and bus data width of the RV64 core.
`define LSU_XLEN 64

// Rename bits carried on top of the five architectural register bits.
`define LSU_RB 2

// ##########################################################################
// On-chip SRAM
// ##########################################################################

// Depth in 64-bit words, so 4 KiB in total.
`define LSU_MEM_WORDS 512

// First byte address answered by the SRAM.
`define LSU_MEM_BASE 64'h0

`endif
